// File: periph_consts.svh
// Bus widths, slot numbers and GPIO register offsets, included by the package and the RTL
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// Peripheral bus widths
`define PERIPH_ADDR_W 11
`define PERIPH_DATA_W 32

// Slot index width, shared by both regions
`define PERIPH_SLOT_W 4

// Address bit that selects the 16-byte slot region
`define PERIPH_REGION_BIT 10

// Full-region slot numbers
`define PERIPH_SLOT_GPIO 1
`define PERIPH_SLOT_UART_RST 2

// GPIO pins and function select width
`define GPIO_PINS 8
`define GPIO_SEL_W 5

// GPIO register offsets inside its 64-byte slot
`define GPIO_OFS_OUT 6'h00
`define GPIO_OFS_IN 6'h04

// Pin selects start here, one word per pin
`define GPIO_OFS_SEL_BASE 6'h20

`endif

// File: periph_pkg.sv
// Shared bus types for the peripheral core, imported by every RTL module
`include "periph_consts.svh"

package periph_pkg;

    // Size code on the read and write strobes, SIZE_NONE means idle
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2,
        SIZE_NONE = 2'd3
    } access_size_e;

    // Request from the core, as seen by every slot
    typedef struct packed {
        logic [`PERIPH_ADDR_W-1:0] addr;
        logic [`PERIPH_DATA_W-1:0] wdata;
        access_size_e              write_n;
        access_size_e              read_n;
    } periph_req_t;

    // Response of one slot
    typedef struct packed {
        logic [`PERIPH_DATA_W-1:0] rdata;
        logic                      ready;
    } periph_rsp_t;

    // Region and slot of an access
    // Same bit layout as a GPIO pin function select
    typedef struct packed {
        logic                      is_byte;
        logic [`PERIPH_SLOT_W-1:0] slot;
    } slot_sel_t;

endpackage

// File: periph_addr_decode.sv
// Address decoder that picks the region and slot and steers the selected read response
`include "periph_consts.svh"

module periph_addr_decode
    import periph_pkg::*;
(
    input  periph_req_t i_req,
    input  periph_rsp_t i_gpio_rsp,
    output logic        o_gpio_sel,
    output periph_rsp_t o_rsp
);

    localparam logic [`PERIPH_SLOT_W-1:0] SLOT_GPIO = `PERIPH_SLOT_GPIO;

    slot_sel_t addr_slot;

    // Byte region has 16-byte slots and full region has 64-byte slots
    always_comb begin
        addr_slot.is_byte = i_req.addr[`PERIPH_REGION_BIT];
        if (addr_slot.is_byte) begin
            addr_slot.slot = i_req.addr[7:4];
        end else begin
            addr_slot.slot = i_req.addr[9:6];
        end
    end

    // Only full-region slot 1 has a peripheral behind it
    assign o_gpio_sel = !addr_slot.is_byte && (addr_slot.slot == SLOT_GPIO);

    always_comb begin
        if (o_gpio_sel) begin
            o_rsp = i_gpio_rsp;
        end else begin
            // Unpopulated slots read as zero and never stall the core
            o_rsp.rdata = '0;
            o_rsp.ready = 1'b1;
        end
    end

endmodule

// File: periph_read_capture.sv
// Output register for read data toward the core, held until the core completes the read
`include "periph_consts.svh"

module periph_read_capture
    import periph_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  access_size_e              i_read_n,
    input  access_size_e              i_write_n,
    input  logic                      i_read_complete,
    input  periph_rsp_t               i_rsp,
    output logic [`PERIPH_DATA_W-1:0] o_rdata,
    output logic                      o_data_ready
);

    logic                      read_active;
    logic                      capture;
    logic                      hold_q;
    logic                      read_ready_q;
    logic [`PERIPH_DATA_W-1:0] rdata_q;

    assign read_active = (i_read_n != SIZE_NONE);

    // Sample once per read, the first cycle the slot is ready
    assign capture = read_active && i_rsp.ready && !hold_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q       <= 1'b0;
            read_ready_q <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold_q <= 1'b0;
            end
            if (capture) begin
                hold_q <= 1'b1;
            end
            // Ready lines up with the registered data
            read_ready_q <= read_active && i_rsp.ready;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            rdata_q <= i_rsp.rdata;
        end
    end

    assign o_rdata = rdata_q;

    // Writes complete in the cycle they are issued
    assign o_data_ready = read_ready_q || (i_write_n != SIZE_NONE);

endmodule

// File: gpio_regs.sv
// GPIO slot with the output register, input pin readback, pin function selects and output mux
`include "periph_consts.svh"

module gpio_regs
    import periph_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_sel,
    input  periph_req_t           i_req,
    input  logic [`GPIO_PINS-1:0] i_ui_in,
    output periph_rsp_t           o_rsp,
    output logic [`GPIO_PINS-1:0] o_uo_out
);

    localparam logic [`PERIPH_SLOT_W-1:0] SLOT_GPIO     = `PERIPH_SLOT_GPIO;
    localparam logic [`PERIPH_SLOT_W-1:0] SLOT_UART_RST = `PERIPH_SLOT_UART_RST;
    localparam int                        IDX_W         = $clog2(`GPIO_PINS);

    logic [5:0]            ofs;
    logic [5:0]            sel_ofs;
    logic                  sel_hit;
    logic [IDX_W-1:0]      sel_idx;
    logic                  wr_en;
    logic [`GPIO_PINS-1:0] out_q;
    slot_sel_t             pin_sel_q [`GPIO_PINS];

    // Offset inside the 64-byte slot
    assign ofs     = i_req.addr[5:0];
    assign sel_ofs = ofs - `GPIO_OFS_SEL_BASE;

    // Word-aligned select registers above the base
    assign sel_hit = (ofs >= `GPIO_OFS_SEL_BASE) && (sel_ofs[1:0] == 2'b00) &&
                     (sel_ofs[5:2] < `GPIO_PINS);
    assign sel_idx = sel_ofs[IDX_W+1:2];

    // Write size is ignored, every register sits in the low byte
    assign wr_en = i_sel && (i_req.write_n != SIZE_NONE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_q <= '0;
        end else if (wr_en && (ofs == `GPIO_OFS_OUT)) begin
            out_q <= i_req.wdata[`GPIO_PINS-1:0];
        end
    end

    for (genvar i = 0; i < `GPIO_PINS; i++) begin : g_pin
        // Pins 0 and 1 default to the UART slot, the rest to GPIO
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                pin_sel_q[i].is_byte <= 1'b0;
                pin_sel_q[i].slot    <= (i < 2) ? SLOT_UART_RST : SLOT_GPIO;
            end else if (wr_en && sel_hit && (sel_idx == IDX_W'(i))) begin
                pin_sel_q[i] <= slot_sel_t'(i_req.wdata[`GPIO_SEL_W-1:0]);
            end
        end

        // A pin routed elsewhere has no driver left and stays low
        always_comb begin
            if (!pin_sel_q[i].is_byte && (pin_sel_q[i].slot == SLOT_GPIO)) begin
                o_uo_out[i] = out_q[i];
            end else begin
                o_uo_out[i] = 1'b0;
            end
        end
    end

    // Register readback, zero-extended
    always_comb begin
        o_rsp.rdata = '0;
        o_rsp.ready = 1'b1;
        if (ofs == `GPIO_OFS_OUT) begin
            o_rsp.rdata[`GPIO_PINS-1:0] = out_q;
        end else if (ofs == `GPIO_OFS_IN) begin
            o_rsp.rdata[`GPIO_PINS-1:0] = i_ui_in;
        end else if (sel_hit) begin
            o_rsp.rdata[`GPIO_SEL_W-1:0] = pin_sel_q[sel_idx];
        end
    end

endmodule

// File: periph_top.sv
// Top of the peripheral bus core, connecting decode, read capture and GPIO to the core bus
`include "periph_consts.svh"

module periph_top
    import periph_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`PERIPH_ADDR_W-1:0] i_addr,
    input  logic [`PERIPH_DATA_W-1:0] i_wdata,
    input  access_size_e              i_write_n,
    input  access_size_e              i_read_n,
    input  logic                      i_read_complete,
    input  logic [`GPIO_PINS-1:0]     i_ui_in,
    output logic [`PERIPH_DATA_W-1:0] o_rdata,
    output logic                      o_data_ready,
    output logic [`GPIO_PINS-1:0]     o_uo_out
);

    periph_req_t req;
    periph_rsp_t gpio_rsp;
    periph_rsp_t sel_rsp;
    logic        gpio_sel;

    // Bundle the core strobes into one request
    assign req = '{addr: i_addr, wdata: i_wdata, write_n: i_write_n, read_n: i_read_n};

    periph_addr_decode u_decode (
        .i_req      (req),
        .i_gpio_rsp (gpio_rsp),
        .o_gpio_sel (gpio_sel),
        .o_rsp      (sel_rsp)
    );

    periph_read_capture u_capture (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_n        (i_read_n),
        .i_write_n       (i_write_n),
        .i_read_complete (i_read_complete),
        .i_rsp           (sel_rsp),
        .o_rdata         (o_rdata),
        .o_data_ready    (o_data_ready)
    );

    gpio_regs u_gpio (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_sel    (gpio_sel),
        .i_req    (req),
        .i_ui_in  (i_ui_in),
        .o_rsp    (gpio_rsp),
        .o_uo_out (o_uo_out)
    );

endmodule

// File: tb_periph_top.sv
// Testbench for periph_top, drives the core bus and checks GPIO registers, pins and read hold
`include "periph_consts.svh"

module tb_periph_top
    import periph_pkg::*;
();

    localparam int                        READY_TIMEOUT = 20;
    localparam int                        DRAIN_TIMEOUT = 20;
    localparam logic [`PERIPH_ADDR_W-1:0] ADDR_OUT      = 11'h040;
    localparam logic [`PERIPH_ADDR_W-1:0] ADDR_IN       = 11'h044;
    localparam logic [`PERIPH_ADDR_W-1:0] ADDR_SEL      = 11'h060;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic [`PERIPH_ADDR_W-1:0] i_addr;
    logic [`PERIPH_DATA_W-1:0] i_wdata;
    access_size_e              i_write_n;
    access_size_e              i_read_n;
    logic                      i_read_complete;
    logic [`GPIO_PINS-1:0]     i_ui_in;
    logic [`PERIPH_DATA_W-1:0] o_rdata;
    logic                      o_data_ready;
    logic [`GPIO_PINS-1:0]     o_uo_out;

    // Expected GPIO state
    logic [`GPIO_PINS-1:0]     model_out;
    logic [`GPIO_PINS-1:0]     model_in;
    logic [`GPIO_SEL_W-1:0]    model_sel [`GPIO_PINS];

    logic [15:0]               lfsr = 16'd36;
    int                        mismatch_errs = 0;
    int                        timeout_errs = 0;

    // Read results waiting for the compare process
    logic [`PERIPH_DATA_W-1:0] got_q [$];
    logic [`PERIPH_DATA_W-1:0] exp_q [$];
    string                     name_q [$];

    periph_top uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_addr          (i_addr),
        .i_wdata         (i_wdata),
        .i_write_n       (i_write_n),
        .i_read_n        (i_read_n),
        .i_read_complete (i_read_complete),
        .i_ui_in         (i_ui_in),
        .o_rdata         (o_rdata),
        .o_data_ready    (o_data_ready),
        .o_uo_out        (o_uo_out)
    );

    always #20 clk = ~clk;

    // 16-bit Galois LFSR, one step per bit
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // Expected read data for a full address
    function automatic logic [`PERIPH_DATA_W-1:0] expected_read(
        input logic [`PERIPH_ADDR_W-1:0] addr
    );
        logic [`PERIPH_DATA_W-1:0] word;
        logic [5:0]                ofs;
        word = '0;
        ofs  = addr[5:0];
        // Only full-region slot 1 has registers
        if (!addr[10] && (addr[9:6] == 4'd1)) begin
            if (ofs == 6'h00) begin
                word[`GPIO_PINS-1:0] = model_out;
            end else if (ofs == 6'h04) begin
                word[`GPIO_PINS-1:0] = model_in;
            end else if ((ofs >= 6'h20) && (ofs[1:0] == 2'b00)) begin
                word[`GPIO_SEL_W-1:0] = model_sel[ofs[4:2]];
            end
        end
        return word;
    endfunction

    // Pins follow the output register only when routed to slot 1
    function automatic logic [`GPIO_PINS-1:0] expected_pins();
        logic [`GPIO_PINS-1:0] pins;
        pins = '0;
        for (int i = 0; i < `GPIO_PINS; i++) begin
            if (model_sel[i] == 5'b0_0001) begin
                pins[i] = model_out[i];
            end
        end
        return pins;
    endfunction

    task automatic check_word(input string name, input logic [`PERIPH_DATA_W-1:0] got,
                              input logic [`PERIPH_DATA_W-1:0] exp);
        if (got !== exp) begin
            mismatch_errs++;
            $display("Mismatch at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic check_pins(input logic [`GPIO_PINS-1:0] got,
                              input logic [`GPIO_PINS-1:0] exp);
        if (got !== exp) begin
            mismatch_errs++;
            $display("Mismatch at %0t: o_uo_out got 0x%02h expected 0x%02h", $time, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_errs++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic queue_read(input string name, input logic [`PERIPH_DATA_W-1:0] got,
                              input logic [`PERIPH_DATA_W-1:0] exp);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    // Compares queued read results against the reference
    always @(negedge clk) begin : compare_reads
        while (got_q.size() > 0) begin
            check_word(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
        end
    end

    // One cycle of write strobe, ready must show in the same cycle
    task automatic write_bus(input logic [`PERIPH_ADDR_W-1:0] addr,
                             input logic [`PERIPH_DATA_W-1:0] data);
        @(negedge clk);
        i_addr    = addr;
        i_wdata   = data;
        i_write_n = SIZE_WORD;
        #10;
        check_flag("o_data_ready", o_data_ready, 1'b1);
        @(negedge clk);
        i_write_n = SIZE_NONE;
    endtask

    // Holds the read strobe, optionally delays read complete while i_ui_in moves
    task automatic read_and_check(input logic [`PERIPH_ADDR_W-1:0] addr, input int hold);
        logic [`PERIPH_DATA_W-1:0] exp;
        logic [31:0]               pin_val;
        string                     name;
        int                        waited;
        @(negedge clk);
        i_addr   = addr;
        i_read_n = SIZE_WORD;
        exp      = expected_read(addr);
        name     = $sformatf("o_rdata (addr 0x%03h)", addr);
        @(negedge clk);
        waited = 1;
        while ((o_data_ready !== 1'b1) && (waited < READY_TIMEOUT)) begin
            @(negedge clk);
            waited++;
        end
        if (o_data_ready !== 1'b1) begin
            timeout_errs++;
            $display("Timeout: read of address 0x%03h never raised o_data_ready", addr);
        end else begin
            queue_read(name, o_rdata, exp);
            for (int c = 0; c < hold; c++) begin
                take_bits(`GPIO_PINS, pin_val);
                i_ui_in  = pin_val[`GPIO_PINS-1:0];
                model_in = pin_val[`GPIO_PINS-1:0];
                @(negedge clk);
                queue_read(name, o_rdata, exp);
                check_flag("o_data_ready", o_data_ready, 1'b1);
            end
            i_read_complete = 1'b1;
            @(negedge clk);
            i_read_complete = 1'b0;
        end
        i_read_n = SIZE_NONE;
    endtask

    initial begin : stimulus
        logic [31:0]            r;
        logic [31:0]            w;
        logic [`GPIO_SEL_W-1:0] v;
        int                     waited;
        rst_n           = 1'b0;
        i_addr          = '0;
        i_wdata         = '0;
        i_write_n       = SIZE_NONE;
        i_read_n        = SIZE_NONE;
        i_read_complete = 1'b0;
        i_ui_in         = '0;
        model_out       = '0;
        model_in        = '0;
        for (int i = 0; i < `GPIO_PINS; i++) begin
            model_sel[i] = (i < 2) ? 5'd`PERIPH_SLOT_UART_RST : 5'd`PERIPH_SLOT_GPIO;
        end
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        // Reset values
        for (int k = 0; k < `GPIO_PINS; k++) begin
            read_and_check(ADDR_SEL + 11'(4 * k), 0);
        end
        read_and_check(ADDR_OUT, 0);
        check_pins(o_uo_out, expected_pins());

        // Output register
        repeat (6) begin
            take_bits(32, w);
            write_bus(ADDR_OUT, w);
            model_out = w[`GPIO_PINS-1:0];
            check_pins(o_uo_out, expected_pins());
            read_and_check(ADDR_OUT, 0);
        end

        // Input pins
        repeat (4) begin
            take_bits(`GPIO_PINS, r);
            i_ui_in  = r[`GPIO_PINS-1:0];
            model_in = r[`GPIO_PINS-1:0];
            read_and_check(ADDR_IN, 0);
        end

        // Pin selects, about half of them routed to GPIO
        repeat (3) begin
            for (int k = 0; k < `GPIO_PINS; k++) begin
                take_bits(1, r);
                if (r[0]) begin
                    v = 5'd1;
                end else begin
                    take_bits(`GPIO_SEL_W, r);
                    v = r[`GPIO_SEL_W-1:0];
                end
                write_bus(ADDR_SEL + 11'(4 * k), {27'd0, v});
                model_sel[k] = v;
                check_pins(o_uo_out, expected_pins());
            end
            for (int k = 0; k < `GPIO_PINS; k++) begin
                read_and_check(ADDR_SEL + 11'(4 * k), 0);
            end
            take_bits(32, w);
            write_bus(ADDR_OUT, w);
            model_out = w[`GPIO_PINS-1:0];
            check_pins(o_uo_out, expected_pins());
        end

        // Other slots read zero, writes there leave GPIO alone
        for (int s = 0; s < 16; s++) begin
            take_bits(4, r);
            if (s != `PERIPH_SLOT_GPIO) begin
                read_and_check(11'(s * 64) + 11'(r[3:0] * 4), 0);
                take_bits(32, w);
                write_bus(11'(s * 64), w);
            end
            read_and_check(11'h400 + 11'(s * 16) + 11'(r[1:0] * 4), 0);
            take_bits(32, w);
            write_bus(11'h400 + 11'(s * 16), w);
            check_pins(o_uo_out, expected_pins());
        end
        take_bits(32, w);
        write_bus(11'h048, w);
        read_and_check(ADDR_OUT, 0);
        check_pins(o_uo_out, expected_pins());

        // Read hold while the input pins change
        take_bits(`GPIO_PINS, r);
        i_ui_in  = r[`GPIO_PINS-1:0];
        model_in = r[`GPIO_PINS-1:0];
        read_and_check(ADDR_IN, 6);
        read_and_check(ADDR_IN, 3);

        waited = 0;
        while ((got_q.size() > 0) && (waited < DRAIN_TIMEOUT)) begin
            @(negedge clk);
            waited++;
        end
        if (got_q.size() > 0) begin
            timeout_errs++;
            $display("Timeout: read results were never compared");
        end

        $display("Errors: %0d mismatches, %0d timeouts", mismatch_errs, timeout_errs);
        if ((mismatch_errs == 0) && (timeout_errs == 0)) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+.
periph_pkg.sv
periph_addr_decode.sv
periph_read_capture.sv
gpio_regs.sv
periph_top.sv
tb_periph_top.sv

// File: Bender.yml
package:
  name: periph_core

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - periph_pkg.sv
      - periph_addr_decode.sv
      - periph_read_capture.sv
      - gpio_regs.sv
      - periph_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_periph_top.sv
